//--- src/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and instruction width
`define XLEN 32
// Register index width, x0..x31
`define REG_ADDR_W 5

// ADDI x0,x0,0 seen by decode in place of a bubble
`define NOP_INSTR 32'h0000_0013

// Younger instructions squashed after a taken redirect
`define FLUSH_CYCLES 2

`endif

//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        I_OP   = 7'b0010011,
        R_OP   = 7'b0110011,
        FENCE  = 7'b0001111
    } t_opcode;

    // Immediate formats
    typedef enum logic [2:0] {
        I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } t_immType;

    // ALU operations, shared by R and I forms
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } t_aluOp;

    // Branch compare, straight from funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } t_branchType;

endpackage

//--- src/core_ctrl_pkg.sv
`include "core_defines.svh"

package core_ctrl_pkg;
    import rv_isa_pkg::*;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU, WB_DMEM, WB_PC4
    } t_selWrBack;

    // Control word, decoded at Q101 and carried to Q105
    typedef struct packed {
        t_opcode                 Opcode;
        logic [`REG_ADDR_W-1:0]  RegDst;
        logic [`REG_ADDR_W-1:0]  RegSrc1;
        logic [`REG_ADDR_W-1:0]  RegSrc2;
        t_aluOp                  AluOp;
        t_branchType             BranchOp;
        t_selWrBack              SelWrBack;
        logic [3:0]              DMemByteEn;
        logic                    SelNextPcAluOutJ; // JAL, JALR
        logic                    SelNextPcAluOutB; // Conditional branch
        logic                    SelAluPc;
        logic                    SelAluImm;
        logic                    Lui;
        logic                    RegWrEn;
        logic                    DMemWrEn;
        logic                    DMemRdEn;
        logic                    SignExt;
    } t_ctrlWord;

endpackage

//--- src/inst_decoder.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module instDecoder
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic [`XLEN-1:0] InstructionQ101H,
    output t_ctrlWord        CtrlQ101H
);

    t_opcode    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       isMem; // Load or store

    assign opcode = t_opcode'(InstructionQ101H[6:0]);
    assign funct3 = InstructionQ101H[14:12];
    assign funct7 = InstructionQ101H[31:25];
    assign isMem  = (opcode == LOAD) || (opcode == STORE);

    always_comb begin
        CtrlQ101H          = '0;
        CtrlQ101H.Opcode   = opcode;
        CtrlQ101H.RegDst   = InstructionQ101H[11:7];
        CtrlQ101H.RegSrc1  = InstructionQ101H[19:15];
        CtrlQ101H.RegSrc2  = InstructionQ101H[24:20];
        CtrlQ101H.BranchOp = t_branchType'(funct3);

        // Next PC and ALU operand selects
        CtrlQ101H.SelNextPcAluOutJ = (opcode == JAL) || (opcode == JALR);
        CtrlQ101H.SelNextPcAluOutB = (opcode == BRANCH);
        CtrlQ101H.SelAluPc  = (opcode == JAL) || (opcode == BRANCH) || (opcode == AUIPC);
        CtrlQ101H.SelAluImm = (opcode != R_OP); // Register operand only for R type
        CtrlQ101H.Lui       = (opcode == LUI);

        CtrlQ101H.RegWrEn = (opcode == LUI)  || (opcode == AUIPC) || (opcode == JAL) ||
                            (opcode == JALR) || (opcode == LOAD)  || (opcode == I_OP) ||
                            (opcode == R_OP) || (opcode == FENCE);
        CtrlQ101H.DMemWrEn = (opcode == STORE);
        CtrlQ101H.DMemRdEn = (opcode == LOAD);
        CtrlQ101H.SignExt  = (opcode == LOAD) && !funct3[2]; // LB, LH

        if (CtrlQ101H.SelNextPcAluOutJ) CtrlQ101H.SelWrBack = WB_PC4; // Link address
        else if (opcode == LOAD)        CtrlQ101H.SelWrBack = WB_DMEM;
        else                            CtrlQ101H.SelWrBack = WB_ALU;

        // Byte lanes, low aligned
        if (isMem) begin
            case (funct3[1:0])
                2'b00:   CtrlQ101H.DMemByteEn = 4'b0001; // Byte
                2'b01:   CtrlQ101H.DMemByteEn = 4'b0011; // Half
                2'b10:   CtrlQ101H.DMemByteEn = 4'b1111; // Word
                default: CtrlQ101H.DMemByteEn = 4'b0000;
            endcase
        end

        // --------------------------------------------------
        // ALU operation
        // --------------------------------------------------
        casez ({funct3, funct7, opcode})
            {3'b000, 7'b0000000, R_OP}: CtrlQ101H.AluOp = ADD;
            {3'b000, 7'b0100000, R_OP}: CtrlQ101H.AluOp = SUB;
            {3'b001, 7'b0000000, R_OP}: CtrlQ101H.AluOp = SLL;
            {3'b010, 7'b0000000, R_OP}: CtrlQ101H.AluOp = SLT;
            {3'b011, 7'b0000000, R_OP}: CtrlQ101H.AluOp = SLTU;
            {3'b100, 7'b0000000, R_OP}: CtrlQ101H.AluOp = XOR;
            {3'b101, 7'b0000000, R_OP}: CtrlQ101H.AluOp = SRL;
            {3'b101, 7'b0100000, R_OP}: CtrlQ101H.AluOp = SRA;
            {3'b110, 7'b0000000, R_OP}: CtrlQ101H.AluOp = OR;
            {3'b111, 7'b0000000, R_OP}: CtrlQ101H.AluOp = AND;
            {3'b010, 7'b???????, I_OP}: CtrlQ101H.AluOp = SLT;  // SLTI
            {3'b011, 7'b???????, I_OP}: CtrlQ101H.AluOp = SLTU; // SLTIU
            {3'b100, 7'b???????, I_OP}: CtrlQ101H.AluOp = XOR;
            {3'b110, 7'b???????, I_OP}: CtrlQ101H.AluOp = OR;
            {3'b111, 7'b???????, I_OP}: CtrlQ101H.AluOp = AND;
            {3'b001, 7'b0000000, I_OP}: CtrlQ101H.AluOp = SLL;  // Shift amount in rs2 field
            {3'b101, 7'b0000000, I_OP}: CtrlQ101H.AluOp = SRL;
            {3'b101, 7'b0100000, I_OP}: CtrlQ101H.AluOp = SRA;
            default:                    CtrlQ101H.AluOp = ADD;  // Address and link adds, ADDI
        endcase
    end

endmodule

//--- src/imm_gen.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module immGen
    import rv_isa_pkg::*;
(
    input  logic [`XLEN-1:0] InstructionQ101H,
    output logic [`XLEN-1:0] ImmediateQ101H
);

    logic [`XLEN-1:0] ins;
    t_immType         immType;

    assign ins = InstructionQ101H;

    // Format from opcode
    always_comb begin
        case (t_opcode'(ins[6:0]))
            JALR, I_OP, LOAD: immType = I_TYPE;
            LUI, AUIPC:       immType = U_TYPE;
            JAL:              immType = J_TYPE;
            BRANCH:           immType = B_TYPE;
            STORE:            immType = S_TYPE;
            default:          immType = I_TYPE;
        endcase
    end

    // Sign bit is always ins[31]
    always_comb begin
        case (immType)
            U_TYPE:  ImmediateQ101H = {ins[31:12], 12'b0};
            S_TYPE:  ImmediateQ101H = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            B_TYPE:  ImmediateQ101H = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            J_TYPE:  ImmediateQ101H = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            default: ImmediateQ101H = {{20{ins[31]}}, ins[31:20]}; // I type
        endcase
    end

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module hazardUnit
    import rv_isa_pkg::*;
(
    input  logic [`XLEN-1:0]       PreInstructionQ101H,
    input  logic                   DMemReady,
    input  logic                   flushActive,
    input  logic [`REG_ADDR_W-1:0] RegDstQ102H,
    input  logic                   LoadValidQ102H,
    input  logic [`REG_ADDR_W-1:0] RegDstQ103H,
    input  logic                   LoadValidQ103H,
    output logic [`XLEN-1:0]       InstructionQ101H,
    output logic                   ValidQ101H,
    output logic                   ReadyQ100H,
    output logic                   ReadyQ101H,
    output logic                   ReadyQ102H
);

    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic                   useRs2;
    logic                   hazardQ102;
    logic                   hazardQ103;
    logic                   loadHazard;
    logic                   insertNop;
    logic                   freeze;

    assign rs1    = PreInstructionQ101H[19:15];
    assign rs2    = PreInstructionQ101H[24:20];
    assign useRs2 = (t_opcode'(PreInstructionQ101H[6:0]) inside {R_OP, STORE, BRANCH});

    // Load result not yet back, one or two stages ahead
    assign hazardQ102 = LoadValidQ102H && ((rs1 == RegDstQ102H) || (useRs2 && rs2 == RegDstQ102H));
    assign hazardQ103 = LoadValidQ103H && ((rs1 == RegDstQ103H) || (useRs2 && rs2 == RegDstQ103H));
    assign loadHazard = hazardQ102 || hazardQ103;

    assign insertNop        = loadHazard || flushActive;
    assign InstructionQ101H = insertNop ? `NOP_INSTR : PreInstructionQ101H; // Bubble
    assign ValidQ101H       = !insertNop;

    // --------------------------------------------------
    // Stage ready levels
    // --------------------------------------------------
    assign freeze     = !DMemReady;
    assign ReadyQ102H = !freeze; // Q102..Q105 move together
    // Flush overrides the stall, squashed word needs no operands
    assign ReadyQ101H = !freeze && (!loadHazard || flushActive);
    assign ReadyQ100H = !freeze && ReadyQ101H;

endmodule

//--- src/flush_timer.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module flushTimer (
    input  logic Clock,
    input  logic reset,
    input  logic ReadyQ102H,
    input  logic SelNextPcAluOutBQ102H,
    input  logic SelNextPcAluOutJQ102H,
    input  logic ValidQ102H,
    input  logic BranchCondMetQ102H,
    output logic SelNextPcAluOutQ102H,
    output logic flushActive
);

    localparam int CntW = $clog2(`FLUSH_CYCLES + 1);

    logic [CntW-1:0] flushCnt; // Remaining squash cycles after the redirect

    // Jump, or branch whose condition holds
    assign SelNextPcAluOutQ102H = ValidQ102H &&
        (SelNextPcAluOutJQ102H || (SelNextPcAluOutBQ102H && BranchCondMetQ102H));

    always_ff @(posedge Clock) begin
        if (reset) begin
            flushCnt <= '0;
        end else if (ReadyQ102H) begin
            if (SelNextPcAluOutQ102H) flushCnt <= CntW'(`FLUSH_CYCLES - 1);
            else if (flushCnt != '0)  flushCnt <= flushCnt - 1'b1;
        end
    end

    assign flushActive = SelNextPcAluOutQ102H || (flushCnt != '0);

endmodule

//--- src/ctrl_pipeline.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module ctrlPipeline
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic                   Clock,
    input  logic                   reset,
    input  logic                   ReadyQ102H,
    input  t_ctrlWord              CtrlQ101H,
    input  logic                   ValidQ101H,
    input  logic                   ReadyQ101H,
    // Q102, execute
    output t_aluOp                 AluOpQ102H,
    output logic                   SelAluPcQ102H,
    output logic                   SelAluImmQ102H,
    output logic                   LuiQ102H,
    output t_branchType            BranchOpQ102H,
    output logic                   SelNextPcAluOutJQ102H,
    output logic                   SelNextPcAluOutBQ102H,
    output logic [`REG_ADDR_W-1:0] RegDstQ102H,
    output logic                   LoadValidQ102H,
    output logic                   ValidQ102H,
    // Q103, memory access
    output logic [`REG_ADDR_W-1:0] RegDstQ103H,
    output logic                   LoadValidQ103H,
    output logic                   DMemWrEnQ103H,
    output logic                   DMemRdEnQ103H,
    output logic [3:0]             DMemByteEnQ103H,
    // Q105, write back
    output logic [`REG_ADDR_W-1:0] RegDstQ105H,
    output logic                   RegWrEnQ105H,
    output t_selWrBack             SelWrBackQ105H,
    output logic                   SignExtQ105H,
    output logic                   ValidInstQ105H
);

    t_ctrlWord  ctrlQ102, ctrlQ103, ctrlQ104, ctrlQ105;
    logic [5:2] preValid; // Index is the stage, 2 for Q102
    logic [5:2] valid;

    // Payload, no reset
    always_ff @(posedge Clock) begin
        if (ReadyQ102H) begin
            ctrlQ102 <= CtrlQ101H;
            ctrlQ103 <= ctrlQ102;
            ctrlQ104 <= ctrlQ103;
            ctrlQ105 <= ctrlQ104;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) preValid <= '0;
        else if (ReadyQ102H) preValid <= {valid[4:2], ValidQ101H && ReadyQ101H};
    end

    assign valid = ReadyQ102H ? preValid : '0; // Nothing valid in a frozen stage

    // --------------------------------------------------
    // Stage outputs
    // --------------------------------------------------
    assign AluOpQ102H            = ctrlQ102.AluOp;
    assign SelAluPcQ102H         = ctrlQ102.SelAluPc;
    assign SelAluImmQ102H        = ctrlQ102.SelAluImm;
    assign LuiQ102H              = ctrlQ102.Lui;
    assign BranchOpQ102H         = ctrlQ102.BranchOp;
    assign SelNextPcAluOutJQ102H = ctrlQ102.SelNextPcAluOutJ;
    assign SelNextPcAluOutBQ102H = ctrlQ102.SelNextPcAluOutB;
    assign RegDstQ102H           = ctrlQ102.RegDst;
    assign LoadValidQ102H        = valid[2] && (ctrlQ102.Opcode == LOAD);
    assign ValidQ102H            = valid[2];

    assign RegDstQ103H     = ctrlQ103.RegDst;
    assign LoadValidQ103H  = valid[3] && (ctrlQ103.Opcode == LOAD);
    assign DMemWrEnQ103H   = valid[3] && ctrlQ103.DMemWrEn;
    assign DMemRdEnQ103H   = valid[3] && ctrlQ103.DMemRdEn;
    assign DMemByteEnQ103H = ctrlQ103.DMemByteEn;

    assign RegDstQ105H    = ctrlQ105.RegDst;
    assign RegWrEnQ105H   = valid[5] && ctrlQ105.RegWrEn;
    assign SelWrBackQ105H = ctrlQ105.SelWrBack;
    assign SignExtQ105H   = ctrlQ105.SignExt;
    assign ValidInstQ105H = valid[5];

endmodule

//--- src/core_ctrl.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module coreCtrl
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic                   Clock,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       PreInstructionQ101H,
    input  logic                   BranchCondMetQ102H,
    input  logic                   DMemReady,
    output logic                   ReadyQ100H,
    output logic                   ReadyQ101H,
    output logic                   ReadyQ102H,
    output logic [`XLEN-1:0]       ImmediateQ101H,
    output logic [`REG_ADDR_W-1:0] RegSrc1Q101H,
    output logic [`REG_ADDR_W-1:0] RegSrc2Q101H,
    output logic                   SelNextPcAluOutQ102H,
    output t_aluOp                 AluOpQ102H,
    output logic                   SelAluPcQ102H,
    output logic                   SelAluImmQ102H,
    output logic                   LuiQ102H,
    output t_branchType            BranchOpQ102H,
    output logic                   DMemWrEnQ103H,
    output logic                   DMemRdEnQ103H,
    output logic [3:0]             DMemByteEnQ103H,
    output logic [`REG_ADDR_W-1:0] RegDstQ105H,
    output logic                   RegWrEnQ105H,
    output t_selWrBack             SelWrBackQ105H,
    output logic                   SignExtQ105H,
    output logic                   ValidInstQ105H
);

    logic [`XLEN-1:0]       InstructionQ101H; // After NOP insertion
    logic                   ValidQ101H;
    t_ctrlWord              CtrlQ101H;
    logic                   flushActive;
    logic                   SelNextPcAluOutJQ102H, SelNextPcAluOutBQ102H;
    logic [`REG_ADDR_W-1:0] RegDstQ102H, RegDstQ103H;
    logic                   LoadValidQ102H, LoadValidQ103H;
    logic                   ValidQ102H;

    assign RegSrc1Q101H = CtrlQ101H.RegSrc1; // Register file read ports
    assign RegSrc2Q101H = CtrlQ101H.RegSrc2;

    hazardUnit hazard (.*);
    instDecoder decoder (.InstructionQ101H, .CtrlQ101H);
    immGen immediate (.InstructionQ101H, .ImmediateQ101H);
    flushTimer flush (.*);
    ctrlPipeline pipe (.*);

endmodule

//--- dv/core_ctrl_properties.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_ctrl_properties (
    input logic Clock,
    input logic reset,
    input logic DMemReady,
    input logic ReadyQ100H,
    input logic ReadyQ101H,
    input logic ReadyQ102H,
    input logic SelNextPcAluOutQ102H,
    input logic ValidQ102H,
    input logic ValidInstQ105H,
    input logic RegWrEnQ105H,
    input logic DMemWrEnQ103H,
    input logic DMemRdEnQ103H
);

    logic [2:0] squashLeft; // Enabled cycles still to be squashed at Q102

    always_ff @(posedge Clock) begin
        if (reset) squashLeft <= '0;
        else if (ReadyQ102H) begin
            if (SelNextPcAluOutQ102H) squashLeft <= 3'(`FLUSH_CYCLES);
            else if (squashLeft != '0) squashLeft <= squashLeft - 1'b1;
        end
    end

    readyOrder: assert property (@(posedge Clock) disable iff (reset)
        ReadyQ100H |-> ReadyQ101H) else $error("ReadyQ100H high with ReadyQ101H low");

    flushSquash: assert property (@(posedge Clock) disable iff (reset)
        (squashLeft != '0) |-> !ValidQ102H) else $error("valid instruction after redirect");

    freezeQ105: assert property (@(posedge Clock) disable iff (reset)
        !DMemReady |-> !ValidInstQ105H) else $error("valid at Q105 during freeze");

    resetQuiet: assert property (@(posedge Clock)
        reset |=> !ValidInstQ105H && !RegWrEnQ105H && !DMemWrEnQ103H &&
                  !DMemRdEnQ103H && !SelNextPcAluOutQ102H)
        else $error("control output active in reset");

endmodule

bind coreCtrl core_ctrl_properties props (.*);

//--- dv/core_ctrl_tb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_ctrl_tb import rv_isa_pkg::*, core_ctrl_pkg::*; ();

    localparam int NumInstr = 2000;
    localparam int MaxCycles = 4 * NumInstr + 16; // Stalls and freezes stay well below this

    logic Clock, reset, dmemReady, branchCond;
    logic [31:0] preInstr;
    logic ReadyQ100H, ReadyQ101H, ReadyQ102H, SelNextPcAluOutQ102H, LuiQ102H;
    logic SelAluPcQ102H, SelAluImmQ102H, DMemWrEnQ103H, DMemRdEnQ103H;
    logic RegWrEnQ105H, SignExtQ105H, ValidInstQ105H;
    logic [31:0] ImmediateQ101H;
    logic [4:0] RegSrc1Q101H, RegSrc2Q101H, RegDstQ105H;
    logic [3:0] DMemByteEnQ103H;
    t_aluOp AluOpQ102H;
    t_branchType BranchOpQ102H;
    t_selWrBack SelWrBackQ105H;

    integer seed = 32'h2e8a_3f73;
    int sent, cycles, errors, i;
    logic advance;               // Fetch may present a new word
    logic mValid [2:5];          // Model stage queue
    logic [31:0] mInstr [2:5];
    logic [1:0] mFlushCnt;
    logic [21:0] heldOut;        // Q102, Q103 and Q105 payload seen last cycle
    logic frozenLast;            // Last cycle had DMemReady low

    coreCtrl uut (.PreInstructionQ101H(preInstr), .BranchCondMetQ102H(branchCond),
        .DMemReady(dmemReady), .*);

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    // --------------------------------------------------
    // Reference rules
    // --------------------------------------------------
    function automatic logic [31:0] expImm(input logic [31:0] w);
        case (w[6:0])
            LUI, AUIPC: return {w[31:12], 12'b0};
            STORE:      return {{20{w[31]}}, w[31:25], w[11:7]};
            BRANCH:     return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            JAL:        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:    return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    function automatic logic [3:0] expByteEn(input logic [31:0] w);
        if (w[6:0] != LOAD && w[6:0] != STORE) return 4'b0000;
        case (w[13:12])
            2'b00:   return 4'b0001;
            2'b01:   return 4'b0011;
            2'b10:   return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic logic expRegWr(input logic [31:0] w);
        return !(w[6:0] == BRANCH || w[6:0] == STORE);
    endfunction

    function automatic logic [1:0] expWrBack(input logic [31:0] w);
        if (w[6:0] == JAL || w[6:0] == JALR) return 2'd2;
        return (w[6:0] == LOAD) ? 2'd1 : 2'd0;
    endfunction

    // Unknown funct7 and non-ALU opcodes fall back to an add
    function automatic t_aluOp expAluOp(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        if (w[6:0] != R_OP && w[6:0] != I_OP) return ADD;
        if (w[6:0] == I_OP && f3 != 3'b001 && f3 != 3'b101) f7 = 7'h00; // No funct7 field
        if (f7 == 7'h20) begin
            if (f3 == 3'b101) return SRA;
            if (f3 == 3'b000 && w[6:0] == R_OP) return SUB;
            return ADD;
        end
        if (f7 != 7'h00) return ADD;
        case (f3)
            3'b000:  return ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    function automatic logic [31:0] randInstr();
        logic [6:0] ops [10];
        logic [6:0] op;
        logic [2:0] f3;
        ops = '{LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, I_OP, R_OP, FENCE};
        op = ops[($random(seed) & 32'h7fff_ffff) % 10];
        f3 = 3'($random(seed));
        if (op == LOAD && f3[1:0] == 2'b11) f3 = 3'b010;
        if (op == STORE) f3[2] = 1'b0;
        // Registers mostly x1..x4 to provoke load-use hazards
        return {$random(seed) & 1 ? 7'h20 : 7'h00, 2'd0, 3'(2'($random(seed))) + 3'd1,
                2'd0, 3'(2'($random(seed))) + 3'd1, f3,
                2'd0, 3'(2'($random(seed))) + 3'd1, op}
               ^ (($random(seed) & 7) == 0 ? 32'h0210_8080 : 32'h0);
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // Model one cycle and check the DUT at the falling edge
    task automatic stepModel();
        logic v2, v3, v5, ld2, ld3, redirect, flushAct, useRs2, hz, nop, rdy101;
        logic [4:0] rs1, rs2;
        logic [6:0] op2;
        logic [21:0] outNow;
        op2 = mInstr[2][6:0];
        v2 = dmemReady && mValid[2];
        v3 = dmemReady && mValid[3];
        v5 = dmemReady && mValid[5];
        ld2 = v2 && mInstr[2][6:0] == LOAD;
        ld3 = v3 && mInstr[3][6:0] == LOAD;
        redirect = v2 && (mInstr[2][6:0] == JAL || mInstr[2][6:0] == JALR ||
                   (mInstr[2][6:0] == BRANCH && branchCond));
        flushAct = redirect || mFlushCnt != 0;
        rs1 = preInstr[19:15];
        rs2 = preInstr[24:20];
        useRs2 = preInstr[6:0] == R_OP || preInstr[6:0] == STORE || preInstr[6:0] == BRANCH;
        hz = (ld2 && (rs1 == mInstr[2][11:7] || (useRs2 && rs2 == mInstr[2][11:7]))) ||
             (ld3 && (rs1 == mInstr[3][11:7] || (useRs2 && rs2 == mInstr[3][11:7])));
        nop = hz || flushAct;
        rdy101 = dmemReady && (!hz || flushAct);

        compare(ReadyQ102H, dmemReady, "ReadyQ102H");
        compare(ReadyQ101H, rdy101, "ReadyQ101H");
        compare(ReadyQ100H, rdy101, "ReadyQ100H");
        compare(SelNextPcAluOutQ102H, redirect, "SelNextPcAluOutQ102H");
        if (!nop) begin
            compare(ImmediateQ101H, expImm(preInstr), "ImmediateQ101H");
            compare(RegSrc1Q101H, preInstr[19:15], "RegSrc1Q101H");
            compare(RegSrc2Q101H, preInstr[24:20], "RegSrc2Q101H");
        end
        if (v2) begin
            compare(AluOpQ102H, expAluOp(mInstr[2]), "AluOpQ102H");
            compare(SelAluPcQ102H, op2 == JAL || op2 == BRANCH || op2 == AUIPC,
                    "SelAluPcQ102H");
            compare(SelAluImmQ102H, op2 != R_OP, "SelAluImmQ102H");
            compare(LuiQ102H, op2 == LUI, "LuiQ102H");
            compare(BranchOpQ102H, mInstr[2][14:12], "BranchOpQ102H");
        end
        compare(DMemWrEnQ103H, v3 && mInstr[3][6:0] == STORE, "DMemWrEnQ103H");
        compare(DMemRdEnQ103H, v3 && mInstr[3][6:0] == LOAD, "DMemRdEnQ103H");
        if (v3) compare(DMemByteEnQ103H, expByteEn(mInstr[3]), "DMemByteEnQ103H");
        compare(ValidInstQ105H, v5, "ValidInstQ105H");
        compare(RegWrEnQ105H, v5 && expRegWr(mInstr[5]), "RegWrEnQ105H");
        if (v5) begin
            compare(RegDstQ105H, mInstr[5][11:7], "RegDstQ105H");
            compare(SelWrBackQ105H, expWrBack(mInstr[5]), "SelWrBackQ105H");
            compare(SignExtQ105H, mInstr[5][6:0] == LOAD && !mInstr[5][14], "SignExtQ105H");
        end

        // Frozen stages keep their payload
        outNow = {AluOpQ102H, SelAluPcQ102H, SelAluImmQ102H, LuiQ102H, BranchOpQ102H,
                  DMemByteEnQ103H, RegDstQ105H, SelWrBackQ105H, SignExtQ105H};
        if (frozenLast) compare(outNow, heldOut, "stage outputs after freeze");
        heldOut = outNow;
        frozenLast = !dmemReady;

        if (dmemReady) begin // Advance the stage queue
            for (int s = 5; s > 2; s--) begin
                mValid[s] = mValid[s-1];
                mInstr[s] = mInstr[s-1];
            end
            mValid[2] = !nop && rdy101;
            mInstr[2] = nop ? `NOP_INSTR : preInstr;
            if (redirect) mFlushCnt = 2'(`FLUSH_CYCLES - 1);
            else if (mFlushCnt != 0) mFlushCnt--;
        end
        advance = rdy101;
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        reset = 1'b1;
        dmemReady = 1'b1;
        branchCond = 1'b0;
        preInstr = `NOP_INSTR;
        errors = 0;
        sent = 0;
        cycles = 0;
        advance = 1'b1;
        frozenLast = 1'b0;
        mFlushCnt = '0;
        for (int s = 2; s <= 5; s++) begin
            mValid[s] = 1'b0;
            mInstr[s] = `NOP_INSTR;
        end
        for (i = 0; i < 16; i++) begin
            @(posedge Clock);
            @(negedge Clock);
            compare({ValidInstQ105H, RegWrEnQ105H, DMemWrEnQ103H, DMemRdEnQ103H,
                     SelNextPcAluOutQ102H}, 5'b0, "control outputs in reset");
        end
        while (sent < NumInstr + 8) begin
            @(posedge Clock);
            reset <= 1'b0;
            dmemReady <= ($random(seed) % 10) != 0; // Freeze about one cycle in ten
            branchCond <= 1'($random(seed));
            if (advance) begin
                preInstr <= (sent < NumInstr) ? randInstr() : `NOP_INSTR; // Drain at the end
                sent++;
            end
            @(negedge Clock);
            stepModel();
            cycles++;
            if (cycles > MaxCycles) begin
                $display("Timeout: pipeline did not accept all instructions in time");
                $display("Done: errors found");
                $fatal(1);
            end
        end
        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule

//--- verilog.f
+incdir+src
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/inst_decoder.sv
src/imm_gen.sv
src/hazard_unit.sv
src/flush_timer.sv
src/ctrl_pipeline.sv
src/core_ctrl.sv
dv/core_ctrl_properties.sv
dv/core_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_ctrl_tb
FILELIST  ?= verilog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
